// File: noc_path_master.f
logic/noc_path_pkg.sv
logic/route_table.sv
logic/port_allocator.sv
logic/route_control_reg.sv
logic/noc_path_master.sv
testbench/tb_noc_path_master.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_noc_path_master
FILELIST = noc_path_master.f
PASS     = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

// File: testbench/tb_noc_path_master.sv
/*
  testbench for the 2x2 mesh path master
  routes rebuilt from router sequences and mesh geometry
  R0 (0,0), R1 (1,0), R2 (0,1), R3 (1,1), x is node bit 0, y is node bit 1
  random requests hold valid and dest until ready
*/
`timescale 1ns/1ps

module tb_noc_path_master;
    import noc_path_pkg::*;

    localparam int n_fields        = n_nodes * n_ports;
    localparam int reset_cycles    = 3;
    localparam int directed_cycles = 66;  // idle, self/cross pairs, conflicts, tail
    localparam int zero_cycles     = 40;
    localparam int random_cycles   = 400;
    localparam int stim_cycles     = reset_cycles + directed_cycles + zero_cycles
                                     + random_cycles;

    // one route as a walk over routers
    typedef struct packed {
        logic        valid;
        logic [4:0]  idx;   // path_free bit
        logic [2:0]  len;   // routers visited
        logic [15:0] seq;   // one hex digit per router, source leftmost
    } trip_t;

    logic                              clock;
    logic                              reset;
    logic [n_paths-1:0]                path_free;
    logic [n_nodes-1:0]                req_valid;
    logic [n_nodes*node_width-1:0]     req_dest;
    logic [n_nodes-1:0]                req_ready;
    logic [n_fields*sel_width-1:0]     route_select;
    logic [n_fields-1:0]               port_active;
    logic [n_nodes-1:0]                response;
    logic [n_fields-1:0]               path_blocked;

    logic [n_nodes-1:0]                exp_ready;   // model grant
    logic [n_fields-1:0]               exp_claim;
    logic [n_fields*sel_width-1:0]     exp_codes;
    logic [n_fields*sel_width-1:0]     exp_select;  // model of select registers
    logic [n_fields-1:0]               pick_ports [n_nodes];
    int                                granted_ports;
    int                                errors = 0;
    int                                cycle_count = 0;

    noc_path_master DUT (
        .clock        (clock),
        .reset        (reset),
        .path_free    (path_free),
        .req_valid    (req_valid),
        .req_dest     (req_dest),
        .req_ready    (req_ready),
        .route_select (route_select),
        .port_active  (port_active),
        .response     (response),
        .path_blocked (path_blocked)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic trip_t make_trip(input int idx, input int len, input int seq);
        trip_t t;
        t.valid = 1'b1;
        t.idx   = idx[4:0];
        t.len   = len[2:0];
        t.seq   = seq[15:0];
        return t;
    endfunction

    // primary when alt is low
    function automatic trip_t trip_of(input logic [1:0] src, input logic [1:0] dst,
                                      input logic alt);
        case ({src, dst, alt})
            {2'd0, 2'd0, 1'b0}: return make_trip(0, 1, 'h0);
            {2'd0, 2'd1, 1'b0}: return make_trip(1, 2, 'h01);
            {2'd0, 2'd1, 1'b1}: return make_trip(2, 4, 'h0231);
            {2'd0, 2'd2, 1'b0}: return make_trip(3, 2, 'h02);
            {2'd0, 2'd2, 1'b1}: return make_trip(4, 4, 'h0132);
            {2'd0, 2'd3, 1'b0}: return make_trip(5, 3, 'h023);
            {2'd0, 2'd3, 1'b1}: return make_trip(6, 3, 'h013);
            {2'd1, 2'd0, 1'b0}: return make_trip(8, 2, 'h10);
            {2'd1, 2'd0, 1'b1}: return make_trip(9, 4, 'h1320);
            {2'd1, 2'd1, 1'b0}: return make_trip(7, 1, 'h1);
            {2'd1, 2'd2, 1'b0}: return make_trip(12, 3, 'h132);
            {2'd1, 2'd2, 1'b1}: return make_trip(13, 3, 'h102);
            {2'd1, 2'd3, 1'b0}: return make_trip(10, 2, 'h13);
            {2'd1, 2'd3, 1'b1}: return make_trip(11, 4, 'h1023);
            {2'd2, 2'd0, 1'b0}: return make_trip(17, 2, 'h20);
            {2'd2, 2'd0, 1'b1}: return make_trip(18, 4, 'h2310);
            {2'd2, 2'd1, 1'b0}: return make_trip(20, 3, 'h231);   // 20 ahead of 19
            {2'd2, 2'd1, 1'b1}: return make_trip(19, 3, 'h201);
            {2'd2, 2'd2, 1'b0}: return make_trip(14, 1, 'h2);
            {2'd2, 2'd3, 1'b0}: return make_trip(15, 2, 'h23);
            {2'd2, 2'd3, 1'b1}: return make_trip(16, 4, 'h2013);
            {2'd3, 2'd0, 1'b0}: return make_trip(26, 3, 'h310);
            {2'd3, 2'd0, 1'b1}: return make_trip(27, 3, 'h320);
            {2'd3, 2'd1, 1'b0}: return make_trip(24, 2, 'h31);
            {2'd3, 2'd1, 1'b1}: return make_trip(25, 4, 'h3201);
            {2'd3, 2'd2, 1'b0}: return make_trip(22, 2, 'h32);
            {2'd3, 2'd2, 1'b1}: return make_trip(23, 4, 'h3102);
            {2'd3, 2'd3, 1'b0}: return make_trip(21, 1, 'h3);
            default:            return '0;  // self routes have no alternate
        endcase
    endfunction

    function automatic logic [1:0] node_at(input trip_t t, input int k);
        return t.seq[4*(int'(t.len)-1-k) +: 2];
    endfunction

    // output port used to step from router a to neighbour b
    function automatic port_e heading(input logic [1:0] a, input logic [1:0] b);
        if (b[0] != a[0])
        begin
            if (b[0])
                return east;
            return west;
        end
        if (b[1])
            return north;
        return south;
    endfunction

    // data leaving east arrives from the west side, and so on
    function automatic sel_e arrival(input port_e p);
        case (p)
            east:    return from_west;
            west:    return from_east;
            north:   return from_south;
            default: return from_north;
        endcase
    endfunction

    function automatic void footprint(input trip_t t, output logic [n_fields-1:0] ports,
                                      output logic [n_fields*sel_width-1:0] codes);
        int    f;
        port_e out;
        sel_e  code;
        ports = '0;
        codes = '0;
        for (int k = 0; k < int'(t.len); k++)
        begin
            if (k == int'(t.len) - 1)
                out = proc;                                  // last router delivers
            else
                out = heading(node_at(t, k), node_at(t, k + 1));
            if (k == 0)
                code = from_proc;
            else
                code = arrival(heading(node_at(t, k - 1), node_at(t, k)));
            f = n_ports * int'(node_at(t, k)) + int'(out);
            ports[f] = 1'b1;
            codes[sel_width*f +: sel_width] = code;
        end
    endfunction

    function automatic logic fits(input trip_t t, input logic [n_paths-1:0] free,
                                  input logic [n_fields-1:0] busy);
        logic [n_fields-1:0]           ports;
        logic [n_fields*sel_width-1:0] codes;
        footprint(t, ports, codes);
        return t.valid && free[t.idx] && ((ports & busy) == '0);
    endfunction

    // three select bits per port bit
    function automatic logic [n_fields*sel_width-1:0] widen(input logic [n_fields-1:0] m);
        logic [n_fields*sel_width-1:0] w;
        w = '0;
        for (int f = 0; f < n_fields; f++)
            w[sel_width*f +: sel_width] = {sel_width{m[f]}};
        return w;
    endfunction

    // priority walk, P0 first, primary before alternate
    always_comb
    begin : model
        trip_t                         pick;
        logic [n_fields-1:0]           busy;
        logic [n_fields-1:0]           ports;
        logic [n_fields*sel_width-1:0] codes;
        logic [n_fields*sel_width-1:0] acc;
        busy      = '0;
        acc       = '0;
        exp_ready = '0;
        for (int i = 0; i < n_nodes; i++)
        begin
            pick = '0;
            if (req_valid[i])
            begin
                if (fits(trip_of(2'(i), req_dest[2*i +: 2], 1'b0), path_free, busy))
                    pick = trip_of(2'(i), req_dest[2*i +: 2], 1'b0);
                else if (fits(trip_of(2'(i), req_dest[2*i +: 2], 1'b1), path_free, busy))
                    pick = trip_of(2'(i), req_dest[2*i +: 2], 1'b1);
            end
            footprint(pick, ports, codes);  // empty for no pick
            pick_ports[i] = ports;
            if (pick.valid)
            begin
                exp_ready[i] = 1'b1;
                busy         = busy | ports;
                acc          = acc | codes;
            end
        end
        exp_claim = busy;
        exp_codes = acc;
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            exp_select <= '0;
        else
            exp_select <= (exp_select & ~widen(exp_claim)) | exp_codes;  // unused hold
    end

    // ports of routes the DUT granted, counted one by one
    always_comb
    begin
        granted_ports = 0;
        for (int i = 0; i < n_nodes; i++)
            if (req_ready[i])
                granted_ports += $countones(pick_ports[i]);
    end

    task automatic count_failure(input string what);
        errors++;
        $display("FAILED at %0t: %s", $time, what);
    endtask

    assert property (@(posedge clock) disable iff (reset) req_ready == exp_ready)
    else count_failure("req_ready differs from the expected grant");
    assert property (@(posedge clock) disable iff (reset) path_blocked == ~exp_claim)
    else count_failure("path_blocked differs from the unclaimed ports");
    assert property (@(posedge clock) disable iff (reset) port_active == $past(exp_claim))
    else count_failure("port_active differs from last cycle's routes");
    assert property (@(posedge clock) disable iff (reset) response == $past(exp_ready))
    else count_failure("response differs from last cycle's grants");
    assert property (@(posedge clock) disable iff (reset) route_select == exp_select)
    else count_failure("route_select differs from the expected codes");
    assert property (@(posedge clock) disable iff (reset)
        $countones(~path_blocked) == granted_ports)
    else count_failure("granted routes share an output port");
    assert property (@(posedge clock) $fell(reset) |->
        port_active == '0 && response == '0 && route_select == '0 && &path_blocked)
    else count_failure("outputs not cleared after reset");
    assert property (@(posedge clock) disable iff (reset)
        path_free == '0 |-> req_ready == '0 && &path_blocked)
    else count_failure("grant with every path disabled");
    assert property (@(posedge clock) disable iff (reset) path_free == '0 |=> response == '0)
    else count_failure("response raised with every path disabled");

    task automatic drive(input logic [n_nodes-1:0] valid, input logic [7:0] dest,
                         input logic [n_paths-1:0] free, input int n);
        repeat (n)
        begin
            req_valid <= valid;
            req_dest  <= dest;
            path_free <= free;
            @(posedge clock);
            cycle_count++;
        end
    endtask

    task automatic random_traffic(input int n, input logic no_paths);
        logic [n_nodes-1:0] valid;
        logic [7:0]         dest;
        valid = '0;
        dest  = '0;
        repeat (n)
        begin
            for (int i = 0; i < n_nodes; i++)
            begin
                if (valid[i] && req_ready[i])
                    valid[i] = 1'b0;  // handshake on the edge just passed
                if (!valid[i] && $urandom_range(1, 0) == 1)
                begin
                    valid[i]       = 1'b1;
                    dest[2*i +: 2] = 2'($urandom_range(3, 0));
                end
            end
            drive(valid, dest, no_paths ? '0 : 28'($urandom | $urandom), 1);  // dense masks
        end
    endtask

    initial
    begin
        trip_t t;
        void'($urandom(32'h08f44dee));
        reset     = 1'b1;
        path_free = '1;
        req_valid = '0;
        req_dest  = '0;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        drive('0, '0, '1, 2);  // quiet after reset
        for (int s = 0; s < n_nodes; s++)
        begin
            for (int d = 0; d < n_nodes; d++)
            begin
                t = trip_of(2'(s), 2'(d), 1'b0);
                drive(4'(1 << s), 8'(d << (2*s)), '1, 1);  // lone request, primary
                drive('0, '0, '1, 1);
                if (s != d)
                begin
                    // primary disabled, alternate takes over
                    drive(4'(1 << s), 8'(d << (2*s)), ~(28'(1) << t.idx), 1);
                    drive('0, '0, '1, 1);
                end
            end
        end
        drive(4'b0101, 8'h11, '1, 2);  // P0 and P2 both to P1, P2 waits
        drive(4'b0100, 8'h10, '1, 1);  // P2 alone
        drive('0, '0, '1, 1);
        drive(4'b0101, 8'h13, '1, 1);  // R2 east lost, P2 goes 2-0-1
        drive('0, '0, '1, 1);
        random_traffic(zero_cycles, 1'b1);
        random_traffic(random_cycles, 1'b0);
        drive('0, '0, '1, 2);
        @(negedge clock);
        $display("errors: %0d after %0d cycles", errors, cycle_count);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #((stim_cycles + 20) * 100);
        $display("watchdog expired, stimulus still running after %0d cycles", cycle_count);
        $display("errors: %0d", errors);
        $display("tests failed");
        $finish;
    end

endmodule

// File: logic/noc_path_master.sv
/*
  central path master for a 2x2 mesh
  requests use valid/ready, ready is combinational in the request cycle
  grants appear on route_select, port_active, response one cycle later
  path_blocked is combinational from current requests and path_free
*/
`timescale 1ns/1ps

module noc_path_master (
    input  logic                                                      clock,
    input  logic                                                      reset,
    input  logic [noc_path_pkg::n_paths-1:0]                          path_free,
    input  logic [noc_path_pkg::n_nodes-1:0]                          req_valid,
    input  logic [noc_path_pkg::n_nodes*noc_path_pkg::node_width-1:0] req_dest,
    output logic [noc_path_pkg::n_nodes-1:0]                          req_ready,
    output logic [noc_path_pkg::n_nodes*noc_path_pkg::n_ports
                  *noc_path_pkg::sel_width-1:0]                       route_select,
    output logic [noc_path_pkg::n_nodes*noc_path_pkg::n_ports-1:0]    port_active,
    output logic [noc_path_pkg::n_nodes-1:0]                          response,
    output logic [noc_path_pkg::n_nodes*noc_path_pkg::n_ports-1:0]    path_blocked
);
    import noc_path_pkg::*;

    localparam int n_fields = n_nodes * n_ports;

    logic [n_fields-1:0]           claim;        // ports granted this cycle
    logic [n_fields-1:0]           select_write;
    logic [n_fields*sel_width-1:0] select_next;

    port_allocator allocator (
        .req_valid    (req_valid),
        .req_dest     (req_dest),
        .path_free    (path_free),
        .req_ready    (req_ready),
        .claim        (claim),
        .select_next  (select_next),
        .select_write (select_write)
    );

    route_control_reg #(
        .n_req       (n_nodes),
        .n_fields    (n_fields),
        .field_width (sel_width)
    ) control (
        .clock        (clock),
        .reset        (reset),
        .req_ready    (req_ready),
        .select_write (select_write),
        .select_next  (select_next),
        .claim        (claim),
        .route_select (route_select),
        .port_active  (port_active),
        .response     (response)
    );

    assign path_blocked = ~claim;  // high = port still free for the mesh

endmodule

// File: logic/route_control_reg.sv
/*
  output registers of the path master
  select fields load only where strobed, others hold their code
  port_active and response follow claim and ready one cycle later
  asynchronous active high reset clears all outputs
*/
`timescale 1ns/1ps

module route_control_reg #(
    parameter int n_req       = noc_path_pkg::n_nodes,
    parameter int n_fields    = noc_path_pkg::n_nodes * noc_path_pkg::n_ports,
    parameter int field_width = noc_path_pkg::sel_width
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [n_req-1:0]                req_ready,
    input  logic [n_fields-1:0]             select_write,
    input  logic [n_fields*field_width-1:0] select_next,
    input  logic [n_fields-1:0]             claim,
    output logic [n_fields*field_width-1:0] route_select,
    output logic [n_fields-1:0]             port_active,
    output logic [n_req-1:0]                response
);

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            route_select <= '0;
            port_active  <= '0;
            response     <= '0;
        end
        else
        begin
            for (int f = 0; f < n_fields; f++)
            begin
                if (select_write[f])  // untouched ports keep last code
                    route_select[f*field_width +: field_width] <=
                        select_next[f*field_width +: field_width];
            end
            port_active <= claim;      // one cycle grant pulse per port
            response    <= req_ready;
        end
    end

    // an active port had its select strobed on the previous edge
    for (genvar f = 0; f < n_fields; f++)
    begin : field_check
        assert property (@(posedge clock) disable iff (reset)
            port_active[f] |-> $past(select_write[f]))
        else $error("port %0d active without a fresh select", f);
    end

endmodule

// File: logic/port_allocator.sv
/*
  fixed priority route allocation, P0 first and P3 last
  a route needs its path_free bit and no port claimed earlier in the chain
  primary is tried before alternate, a lost request simply retries
  fully combinational, ready is the grant
*/
`timescale 1ns/1ps

module port_allocator (
    input  logic [noc_path_pkg::n_nodes-1:0]                          req_valid,
    input  logic [noc_path_pkg::n_nodes*noc_path_pkg::node_width-1:0] req_dest,
    input  logic [noc_path_pkg::n_paths-1:0]                          path_free,
    output logic [noc_path_pkg::n_nodes-1:0]                          req_ready,
    output logic [noc_path_pkg::n_nodes*noc_path_pkg::n_ports-1:0]    claim,
    output logic [noc_path_pkg::n_nodes*noc_path_pkg::n_ports
                  *noc_path_pkg::sel_width-1:0]                       select_next,
    output logic [noc_path_pkg::n_nodes*noc_path_pkg::n_ports-1:0]    select_write
);
    import noc_path_pkg::*;

    localparam int n_fields = n_nodes * n_ports;  // one per router output port

    route_t                        primary   [n_nodes];
    route_t                        alternate [n_nodes];
    logic [n_fields-1:0]           taken;  // union of granted routes
    logic [n_fields*sel_width-1:0] codes;  // chosen select codes

    for (genvar i = 0; i < n_nodes; i++)
    begin : lookup
        route_table routes (
            .source    (node_width'(i)),                          // own processor
            .dest      (req_dest[i*node_width +: node_width]),
            .primary   (primary[i]),
            .alternate (alternate[i])
        );
    end

    // usable when enabled and clear of earlier claims
    function automatic logic fits(input route_t r, input logic [n_paths-1:0] free,
                                  input logic [n_fields-1:0] busy);
        return r.valid && free[r.index] && ((r.used & busy) == '0);
    endfunction

    always_comb
    begin : allocate
        route_t                        pick;
        logic [n_fields-1:0]           busy;
        logic [n_fields*sel_width-1:0] acc;
        busy      = '0;
        acc       = '0;
        req_ready = '0;
        for (int i = 0; i < n_nodes; i++)  // priority order
        begin
            pick = '0;
            if (req_valid[i])
            begin
                if (fits(primary[i], path_free, busy))
                    pick = primary[i];
                else if (fits(alternate[i], path_free, busy))
                    pick = alternate[i];
            end
            if (pick.valid)
            begin
                req_ready[i] = 1'b1;
                busy         = busy | pick.used;
                acc          = acc | pick.code;  // ports are disjoint, plain or merges
            end
        end
        taken = busy;
        codes = acc;
    end

    assign claim        = taken;
    assign select_write = taken;  // every claimed port gets a fresh code
    assign select_next  = codes;

endmodule

// File: logic/route_table.sv
/*
  constant route lookup for one source processor
  mesh: R0 bottom left, R1 east of R0, R2 north of R0, R3 north of R1
  every cross pair has a primary and an alternate route
  self routes use the local processor port only, alternate is invalid
*/
`timescale 1ns/1ps

module route_table (
    input  logic [noc_path_pkg::node_width-1:0] source,
    input  logic [noc_path_pkg::node_width-1:0] dest,
    output noc_path_pkg::route_t                primary,
    output noc_path_pkg::route_t                alternate
);
    import noc_path_pkg::*;

    // one output port of one router on the way
    typedef struct packed {
        logic                  on;
        logic [node_width-1:0] node;
        port_e                 port;
        sel_e                  code;
    } hop_t;

    localparam hop_t none = '0;  // unused hop slot

    function automatic hop_t hop(input int node, input port_e port, input sel_e code);
        hop_t h;
        h.on   = 1'b1;
        h.node = node[node_width-1:0];
        h.port = port;
        h.code = code;
        return h;
    endfunction

    // up to four hops, source router first
    function automatic route_t path(input int idx, input hop_t h0, input hop_t h1,
                                    input hop_t h2, input hop_t h3);
        route_t r;
        hop_t   hops [4];
        r       = '0;
        r.valid = 1'b1;
        r.index = idx[$clog2(n_paths)-1:0];
        hops    = '{h0, h1, h2, h3};
        foreach (hops[k])
        begin
            if (hops[k].on)
            begin
                r.used[hops[k].node][hops[k].port] = 1'b1;
                r.code[hops[k].node][hops[k].port] = hops[k].code;
            end
        end
        return r;
    endfunction

    always_comb
    begin
        primary   = '0;
        alternate = '0;  // stays invalid for self routes
        case ({source, dest})
            {2'd0, 2'd0}: primary = path(0, hop(0, proc, from_proc), none, none, none);
            {2'd0, 2'd1}:
            begin
                primary   = path(1, hop(0, east, from_proc), hop(1, proc, from_west), none, none);
                alternate = path(2, hop(0, north, from_proc), hop(2, east, from_south),
                                 hop(3, south, from_west), hop(1, proc, from_north)); // 0-2-3-1
            end
            {2'd0, 2'd2}:
            begin
                primary   = path(3, hop(0, north, from_proc), hop(2, proc, from_south), none, none);
                alternate = path(4, hop(0, east, from_proc), hop(1, north, from_west),
                                 hop(3, west, from_south), hop(2, proc, from_east)); // 0-1-3-2
            end
            {2'd0, 2'd3}:
            begin
                primary   = path(5, hop(0, north, from_proc), hop(2, east, from_south),
                                 hop(3, proc, from_west), none);              // 0-2-3
                alternate = path(6, hop(0, east, from_proc), hop(1, north, from_west),
                                 hop(3, proc, from_south), none);             // 0-1-3
            end
            {2'd1, 2'd0}:
            begin
                primary   = path(8, hop(1, west, from_proc), hop(0, proc, from_east), none, none);
                alternate = path(9, hop(1, north, from_proc), hop(3, west, from_south),
                                 hop(2, south, from_east), hop(0, proc, from_north)); // 1-3-2-0
            end
            {2'd1, 2'd1}: primary = path(7, hop(1, proc, from_proc), none, none, none);
            {2'd1, 2'd2}:
            begin
                primary   = path(12, hop(1, north, from_proc), hop(3, west, from_south),
                                 hop(2, proc, from_east), none);              // 1-3-2
                alternate = path(13, hop(1, west, from_proc), hop(0, north, from_east),
                                 hop(2, proc, from_south), none);             // 1-0-2
            end
            {2'd1, 2'd3}:
            begin
                primary   = path(10, hop(1, north, from_proc), hop(3, proc, from_south), none, none);
                alternate = path(11, hop(1, west, from_proc), hop(0, north, from_east),
                                 hop(2, east, from_south), hop(3, proc, from_west)); // 1-0-2-3
            end
            {2'd2, 2'd0}:
            begin
                primary   = path(17, hop(2, south, from_proc), hop(0, proc, from_north), none, none);
                alternate = path(18, hop(2, east, from_proc), hop(3, south, from_west),
                                 hop(1, west, from_north), hop(0, proc, from_east)); // 2-3-1-0
            end
            {2'd2, 2'd1}:
            begin
                // index 20 is tried before 19 here
                primary   = path(20, hop(2, east, from_proc), hop(3, south, from_west),
                                 hop(1, proc, from_north), none);             // 2-3-1
                alternate = path(19, hop(2, south, from_proc), hop(0, east, from_north),
                                 hop(1, proc, from_west), none);              // 2-0-1
            end
            {2'd2, 2'd2}: primary = path(14, hop(2, proc, from_proc), none, none, none);
            {2'd2, 2'd3}:
            begin
                primary   = path(15, hop(2, east, from_proc), hop(3, proc, from_west), none, none);
                alternate = path(16, hop(2, south, from_proc), hop(0, east, from_north),
                                 hop(1, north, from_west), hop(3, proc, from_south)); // 2-0-1-3
            end
            {2'd3, 2'd0}:
            begin
                primary   = path(26, hop(3, south, from_proc), hop(1, west, from_north),
                                 hop(0, proc, from_east), none);              // 3-1-0
                alternate = path(27, hop(3, west, from_proc), hop(2, south, from_east),
                                 hop(0, proc, from_north), none);             // 3-2-0
            end
            {2'd3, 2'd1}:
            begin
                primary   = path(24, hop(3, south, from_proc), hop(1, proc, from_north), none, none);
                alternate = path(25, hop(3, west, from_proc), hop(2, south, from_east),
                                 hop(0, east, from_north), hop(1, proc, from_west)); // 3-2-0-1
            end
            {2'd3, 2'd2}:
            begin
                primary   = path(22, hop(3, west, from_proc), hop(2, proc, from_east), none, none);
                alternate = path(23, hop(3, south, from_proc), hop(1, west, from_north),
                                 hop(0, north, from_east), hop(2, proc, from_south)); // 3-1-0-2
            end
            {2'd3, 2'd3}: primary = path(21, hop(3, proc, from_proc), none, none, none);
        endcase
    end

endmodule

// File: logic/noc_path_pkg.sv
/*
  sizes and shared types of the 2x2 mesh path master
  route_t is laid out for exactly four routers of five ports each
  select codes name the input that feeds an output port
  path-free indices run 0..27, seven per source processor
*/
package noc_path_pkg;

    parameter int n_nodes    = 4;   // routers, one processor each
    parameter int n_ports    = 5;   // north south east west processor
    parameter int n_paths    = 28;  // 24 cross routes + 4 self routes
    parameter int sel_width  = 3;   // one input select field
    parameter int node_width = 2;   // destination number

    // bit position of a port inside one router's active slice
    typedef enum logic [$clog2(n_ports)-1:0] {
        proc  = 3'd0,
        west  = 3'd1,
        east  = 3'd2,
        south = 3'd3,
        north = 3'd4
    } port_e;

    // where the data of an output port comes from
    typedef enum logic [sel_width-1:0] {
        from_north = 3'd0,
        from_south = 3'd1,
        from_east  = 3'd2,
        from_west  = 3'd3,
        from_proc  = 3'd4
    } sel_e;

    // one candidate route through the mesh, 86 bits
    typedef struct packed {
        logic                                        valid;  // low for a missing alternate
        logic [$clog2(n_paths)-1:0]                  index;  // bit in path_free
        logic [n_nodes-1:0][n_ports-1:0]             used;   // output ports taken
        logic [n_nodes-1:0][n_ports-1:0][sel_width-1:0] code; // zero where unused
    } route_t;

endpackage
